// ==== accel_top.f ====
+incdir+source
source/accel_pkg.sv
source/stream_fifo.sv
source/accel_regs.sv
source/vec_read_unit.sv
source/vec_write_unit.sv
source/accel_top.sv
tests/accel_props.sv
tests/accel_tb.sv

// ==== tests/accel_tb.sv ====
`include "accel_defs.svh"

module accel_tb
   import accel_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_ROWS = 6;
   localparam int MEM_WORDS = 1024;

   typedef struct packed {
      logic [`ACCEL_LEN_W-1:0]  len;
      logic [`ACCEL_DATA_W-1:0] scale;
      logic [`ACCEL_ADDR_W-1:0] rd_base;
      logic [`ACCEL_ADDR_W-1:0] wr_base;
      logic                     rd_bp;
      logic                     wr_bp;
      logic                     clear_first;
   } test_row_t;

   // basic, random stalls, empty job, clear first, then two back to back
   test_row_t rows [NUM_ROWS] = '{
      '{8'd8,  32'd3,          16'h000, 16'h100, 1'b0, 1'b0, 1'b0},
      '{8'd20, 32'h0001_2345,  16'h040, 16'h180, 1'b1, 1'b1, 1'b0},
      '{8'd0,  32'd7,          16'h000, 16'h1f0, 1'b0, 1'b0, 1'b0},
      '{8'd12, 32'hffff_fff3,  16'h0a0, 16'h200, 1'b0, 1'b1, 1'b1},
      '{8'd16, 32'd5,          16'h100, 16'h240, 1'b1, 1'b0, 1'b0},
      '{8'd16, 32'h8000_0001,  16'h120, 16'h260, 1'b1, 1'b1, 1'b0}
   };

   logic                       clk;
   logic                       rst;
   logic                       valid;
   logic [`ACCEL_ADDR_W-1:0]   addr;
   logic                       wstrb;
   logic [`ACCEL_DATA_W-1:0]   wdata;
   logic                       ready;
   logic [`ACCEL_DATA_W-1:0]   rdata;
   logic                       rd_valid;
   logic [`ACCEL_ADDR_W-1:0]   rd_addr;
   logic                       rd_ready;
   logic [`ACCEL_DATA_W-1:0]   rd_rdata;
   logic                       wr_valid;
   logic [`ACCEL_ADDR_W-1:0]   wr_addr;
   logic [`ACCEL_DATA_W-1:0]   wr_wdata;
   logic [`ACCEL_DATA_W/8-1:0] wr_wstrb;
   logic                       wr_ready;

   logic [31:0] rng_state = 32'hf30cc9e3;
   logic [31:0] rnd;
   logic [31:0] rd_mem [MEM_WORDS];
   logic [31:0] wr_mem [MEM_WORDS];
   logic        wr_hit [MEM_WORDS];
   logic        rd_bp;
   logic        wr_bp;
   int          cur_wr_base;
   int          cur_len;
   int          wr_count;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_passed = 0;

   accel_top u_accel_top (.*);

   // read memory answers in the same cycle
   assign rd_rdata = rd_mem[rd_addr[9:0]];

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // 200 cycles per test plus 40 per pair, over the table and the readback
   function automatic int budget_cycles();
      int total;
      total = 200;
      for (int n = 0; n < NUM_ROWS; n++) begin
         total = total + 200 + 40 * int'(rows[n].len);
      end
      return total;
   endfunction

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin : watchdog
      int limit;
      int cycles;
      limit = budget_cycles();
      cycles = 0;
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
   end

   // ready pattern per bus from one random word per cycle
   always @(negedge clk) begin
      rnd = next_random();
      rd_ready = rd_bp ? rnd[0] : 1'b1;
      wr_ready = wr_bp ? rnd[1] : 1'b1;
   end

   // write memory capture with window and duplicate checks
   always @(posedge clk) begin
      if (!rst && wr_valid && wr_ready) begin
         wr_count++;
         if (wr_wstrb != '1) begin
            $display("** Error at %0t: write strobe %h is not all ones", $time, wr_wstrb);
            errors++;
         end
         if (int'(wr_addr) < cur_wr_base || int'(wr_addr) >= cur_wr_base + cur_len) begin
            $display("** Error at %0t: write to %h outside the result window", $time, wr_addr);
            errors++;
         end else if (wr_hit[wr_addr[9:0]]) begin
            $display("** Error at %0t: second write to %h", $time, wr_addr);
            errors++;
         end else begin
            wr_hit[wr_addr[9:0]] = 1'b1;
            wr_mem[wr_addr[9:0]] = wr_wdata;
         end
      end
   end

   task automatic cpu_write(input reg_sel_e sel, input logic [31:0] data);
      @(negedge clk);
      valid = 1'b1;
      addr = `ACCEL_ADDR_W'(sel);
      wstrb = 1'b1;
      wdata = data;
      @(negedge clk);
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   // rdata is combinational and sampled mid low phase
   task automatic cpu_read(input reg_sel_e sel, output logic [31:0] data);
      @(negedge clk);
      valid = 1'b1;
      addr = `ACCEL_ADDR_W'(sel);
      wstrb = 1'b0;
      #10;
      data = rdata;
      if (ready !== 1'b1) begin
         $display("** Error at %0t: cpu ready is %b, expected 1", $time, ready);
         errors++;
      end
      @(negedge clk);
      valid = 1'b0;
   endtask

   task automatic expect_reg(input reg_sel_e sel, input logic [31:0] exp);
      logic [31:0] v;
      cpu_read(sel, v);
      if (v !== exp) begin
         $display("** Error at %0t: register %s reads %h, expected %h",
                  $time, sel.name(), v, exp);
         errors++;
      end
   endtask

   task automatic check_readback();
      int errs_before;
      errs_before = errors;
      expect_reg(REG_STATUS, 32'h0);
      cpu_write(REG_RD_BASE, 32'h0000_1234);
      cpu_write(REG_WR_BASE, 32'h0000_0abc);
      cpu_write(REG_LEN, 32'h0000_005a);
      cpu_write(REG_SCALE, 32'hdead_beef);
      expect_reg(REG_RD_BASE, 32'h0000_1234);
      expect_reg(REG_WR_BASE, 32'h0000_0abc);
      expect_reg(REG_LEN, 32'h0000_005a);
      expect_reg(REG_SCALE, 32'hdead_beef);
      tests_run++;
      if (errors == errs_before) tests_passed++;
      $display("register readback: %s", (errors == errs_before) ? "ok" : "FAILED");
   endtask

   task automatic run_row(input int n);
      test_row_t   row;
      logic [31:0] v;
      logic [31:0] bias;
      logic [31:0] weight;
      logic [31:0] expected;
      int          errs_before;
      int          idx;
      row = rows[n];
      errs_before = errors;
      if (row.clear_first) begin
         cpu_write(REG_CTRL, 32'h2);
         expect_reg(REG_STATUS, 32'h0);
      end
      cpu_write(REG_RD_BASE, 32'(row.rd_base));
      cpu_write(REG_WR_BASE, 32'(row.wr_base));
      cpu_write(REG_LEN, 32'(row.len));
      cpu_write(REG_SCALE, row.scale);
      rd_bp = row.rd_bp;
      wr_bp = row.wr_bp;
      cur_wr_base = int'(row.wr_base);
      cur_len = int'(row.len);
      wr_count = 0;
      for (int a = 0; a < MEM_WORDS; a++) wr_hit[a] = 1'b0;
      cpu_write(REG_CTRL, 32'h1);
      cpu_read(REG_STATUS, v);
      if (row.len != '0 && v[0] !== 1'b0) begin
         $display("** Error at %0t: done still set right after the run write", $time);
         errors++;
      end
      while (v[0] !== 1'b1) cpu_read(REG_STATUS, v);
      if (wr_count != cur_len) begin
         $display("** Error at %0t: %0d writes, expected %0d", $time, wr_count, cur_len);
         errors++;
      end
      for (int i = 0; i < cur_len; i++) begin
         idx = int'(row.rd_base) + 2 * i;
         bias = rd_mem[idx];
         weight = rd_mem[idx + 1];
         expected = bias + weight * row.scale;
         if (!wr_hit[cur_wr_base + i]) begin
            $display("** Error at %0t: no write to %h", $time, cur_wr_base + i);
            errors++;
         end else if (wr_mem[cur_wr_base + i] !== expected) begin
            $display("** Error at %0t: word %0d is %h, expected %h",
                     $time, i, wr_mem[cur_wr_base + i], expected);
            errors++;
         end
      end
      tests_run++;
      if (errors == errs_before) tests_passed++;
      $display("row %0d, len %0d, stalls rd %0b wr %0b: %s", n, cur_len, row.rd_bp,
               row.wr_bp, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      rst = 1'b1;
      valid = 1'b0;
      addr = '0;
      wstrb = 1'b0;
      wdata = '0;
      rd_ready = 1'b1;
      wr_ready = 1'b1;
      rd_bp = 1'b0;
      wr_bp = 1'b0;
      cur_wr_base = 0;
      cur_len = 0;
      wr_count = 0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         rd_mem[a] = next_random() ^ 32'(a);
         wr_hit[a] = 1'b0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_readback();
      for (int n = 0; n < NUM_ROWS; n++) run_row(n);
      $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_passed, tests_run - tests_passed, errors,
               u_accel_top.u_accel_props.fail_count);
      if (errors == 0 && u_accel_top.u_accel_props.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== tests/accel_props.sv ====
`include "accel_defs.svh"

module accel_props (
   input logic                     clk,
   input logic                     rst,
   input logic                     valid,
   input logic [`ACCEL_ADDR_W-1:0] addr,
   input logic                     wstrb,
   input logic [`ACCEL_DATA_W-1:0] wdata,
   input logic                     rd_valid,
   input logic                     rd_ready,
   input logic [`ACCEL_ADDR_W-1:0] rd_addr,
   input logic                     wr_valid,
   input logic                     wr_ready,
   input logic [`ACCEL_ADDR_W-1:0] wr_addr,
   input logic [`ACCEL_DATA_W-1:0] wr_wdata,
   input logic                     job_run
);
   timeunit 1ns;
   timeprecision 100ps;

   logic run_seen;
   logic run_write;
   int   fail_count = 0;

   // cpu write of the run bit to ctrl
   assign run_write = valid && wstrb && (addr == `ACCEL_ADDR_W'(`ACCEL_REG_CTRL))
                      && wdata[`ACCEL_CTRL_RUN_BIT];

   // set by the first run pulse after reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_seen <= 1'b0;
      end else if (job_run) begin
         run_seen <= 1'b1;
      end
   end

   a_rd_hold: assert property (@(posedge clk) disable iff (rst)
      rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
      else begin
         $error("read request changed while stalled");
         fail_count++;
      end

   a_wr_hold: assert property (@(posedge clk) disable iff (rst)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_wdata))
      else begin
         $error("write request changed while stalled");
         fail_count++;
      end

   // pulse comes one cycle after the run write and never twice in a row
   a_run_pulse: assert property (@(posedge clk) disable iff (rst)
      job_run |-> $past(run_write) && !$past(job_run))
      else begin
         $error("run pulse not a single cycle after the run write");
         fail_count++;
      end

   a_no_early_write: assert property (@(posedge clk) disable iff (rst)
      !run_seen |-> !wr_valid)
      else begin
         $error("write request before the first run");
         fail_count++;
      end

endmodule

bind accel_top accel_props u_accel_props (
   .clk      (clk),
   .rst      (rst),
   .valid    (valid),
   .addr     (addr),
   .wstrb    (wstrb),
   .wdata    (wdata),
   .rd_valid (rd_valid),
   .rd_ready (rd_ready),
   .rd_addr  (rd_addr),
   .wr_valid (wr_valid),
   .wr_ready (wr_ready),
   .wr_addr  (wr_addr),
   .wr_wdata (wr_wdata),
   .job_run  (job_run)
);

// ==== source/accel_top.sv ====
`include "accel_defs.svh"

module accel_top
   import accel_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   // cpu port
   input  logic                       valid,
   input  logic [`ACCEL_ADDR_W-1:0]   addr,
   input  logic                       wstrb,
   input  logic [`ACCEL_DATA_W-1:0]   wdata,
   output logic                       ready,
   output logic [`ACCEL_DATA_W-1:0]   rdata,
   // read databus
   output logic                       rd_valid,
   output logic [`ACCEL_ADDR_W-1:0]   rd_addr,
   input  logic                       rd_ready,
   input  logic [`ACCEL_DATA_W-1:0]   rd_rdata,
   // write databus
   output logic                       wr_valid,
   output logic [`ACCEL_ADDR_W-1:0]   wr_addr,
   output logic [`ACCEL_DATA_W-1:0]   wr_wdata,
   output logic [`ACCEL_DATA_W/8-1:0] wr_wstrb,
   input  logic                       wr_ready
);

   logic [`ACCEL_ADDR_W-1:0] rd_base;
   logic [`ACCEL_ADDR_W-1:0] wr_base;
   logic [`ACCEL_LEN_W-1:0]  len;
   logic [`ACCEL_DATA_W-1:0] scale;
   logic                     job_run;
   logic                     job_clear;
   logic                     job_done;

   // read unit to pair fifo
   logic                     push_valid;
   logic                     push_ready;
   flow_pair_t               push_data;

   // pair fifo to write unit
   logic                     pair_valid;
   logic                     pair_ready;
   flow_pair_t               pair_data;

   accel_regs u_accel_regs (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .addr      (addr),
      .wstrb     (wstrb),
      .wdata     (wdata),
      .ready     (ready),
      .rdata     (rdata),
      .job_done  (job_done),
      .rd_base   (rd_base),
      .wr_base   (wr_base),
      .len       (len),
      .scale     (scale),
      .job_run   (job_run),
      .job_clear (job_clear)
   );

   vec_read_unit u_vec_read_unit (
      .clk        (clk),
      .rst        (rst),
      .job_run    (job_run),
      .job_clear  (job_clear),
      .rd_base    (rd_base),
      .len        (len),
      .rd_valid   (rd_valid),
      .rd_addr    (rd_addr),
      .pair_valid (push_valid),
      .pair_data  (push_data),
      .rd_ready   (rd_ready),
      .rd_rdata   (rd_rdata),
      .pair_space (push_ready)
   );

   stream_fifo #(
      .payload_t (flow_pair_t),
      .DEPTH     (`ACCEL_FIFO_DEPTH)
   ) u_pair_fifo (
      .clk       (clk),
      .rst       (rst),
      .flush     (job_clear),
      .in_valid  (push_valid),
      .in_ready  (push_ready),
      .in_data   (push_data),
      .out_valid (pair_valid),
      .out_ready (pair_ready),
      .out_data  (pair_data)
   );

   vec_write_unit u_vec_write_unit (
      .clk        (clk),
      .rst        (rst),
      .job_run    (job_run),
      .job_clear  (job_clear),
      .wr_base    (wr_base),
      .len        (len),
      .scale      (scale),
      .pair_valid (pair_valid),
      .pair_data  (pair_data),
      .pair_ready (pair_ready),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_wdata   (wr_wdata),
      .wr_wstrb   (wr_wstrb),
      .job_done   (job_done),
      .wr_ready   (wr_ready)
   );

endmodule

// ==== source/vec_write_unit.sv ====
`include "accel_defs.svh"

module vec_write_unit
   import accel_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       job_run,
   input  logic                       job_clear,
   input  logic [`ACCEL_ADDR_W-1:0]   wr_base,
   input  logic [`ACCEL_LEN_W-1:0]    len,
   input  logic [`ACCEL_DATA_W-1:0]   scale,
   input  logic                       pair_valid,
   input  flow_pair_t                 pair_data,
   output logic                       pair_ready,
   output logic                       wr_valid,
   output logic [`ACCEL_ADDR_W-1:0]   wr_addr,
   output logic [`ACCEL_DATA_W-1:0]   wr_wdata,
   output logic [`ACCEL_DATA_W/8-1:0] wr_wstrb,
   output logic                       job_done,
   input  logic                       wr_ready
);

   logic [`ACCEL_DATA_W-1:0] mac;
   logic [`ACCEL_ADDR_W-1:0] tag_addr_r;
   logic [`ACCEL_LEN_W-1:0]  wr_cnt;
   logic                     busy_r;
   result_t                  res_in;
   result_t                  res_out;
   logic                     res_in_ready;
   logic                     res_valid;
   logic                     pop;
   logic                     wr_fire;
   logic                     last_write;
   logic                     zero_job;

   // bias + weight * scale, kept to the data width
   assign mac = pair_data.bias + pair_data.weight * scale;

   assign res_in = '{addr: tag_addr_r, data: mac};

   // a full result fifo stalls the pair stream
   assign pair_ready = res_in_ready;
   assign pop        = pair_valid & pair_ready;

   stream_fifo #(
      .payload_t (result_t),
      .DEPTH     (`ACCEL_FIFO_DEPTH)
   ) u_res_fifo (
      .clk       (clk),
      .rst       (rst),
      .flush     (job_clear),
      .in_valid  (pair_valid),
      .in_ready  (res_in_ready),
      .in_data   (res_in),
      .out_valid (res_valid),
      .out_ready (wr_ready),
      .out_data  (res_out)
   );

   // write databus straight off the fifo head
   assign wr_valid = res_valid;
   assign wr_addr  = res_out.addr;
   assign wr_wdata = res_out.data;
   assign wr_wstrb = '1;
   assign wr_fire  = wr_valid & wr_ready;

   // completion, either the final accepted write or an empty job
   assign last_write = busy_r & wr_fire & (wr_cnt == len - 1'b1);
   assign zero_job   = job_run & (len == '0);
   assign job_done   = last_write | zero_job;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tag_addr_r <= '0;
         wr_cnt     <= '0;
         busy_r     <= 1'b0;
      end else if (job_clear) begin
         tag_addr_r <= '0;
         wr_cnt     <= '0;
         busy_r     <= 1'b0;
      end else if (job_run) begin
         tag_addr_r <= wr_base;
         wr_cnt     <= '0;
         busy_r     <= (len != '0);
      end else begin
         // next address goes to the next popped pair
         if (pop) begin
            tag_addr_r <= tag_addr_r + 1'b1;
         end
         if (wr_fire) begin
            wr_cnt <= wr_cnt + 1'b1;
         end
         if (last_write) begin
            busy_r <= 1'b0;
         end
      end
   end

endmodule

// ==== source/vec_read_unit.sv ====
`include "accel_defs.svh"

module vec_read_unit
   import accel_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     job_run,
   input  logic                     job_clear,
   input  logic [`ACCEL_ADDR_W-1:0] rd_base,
   input  logic [`ACCEL_LEN_W-1:0]  len,
   output logic                     rd_valid,
   output logic [`ACCEL_ADDR_W-1:0] rd_addr,
   output logic                     pair_valid,
   output flow_pair_t               pair_data,
   input  logic                     rd_ready,
   input  logic [`ACCEL_DATA_W-1:0] rd_rdata,
   input  logic                     pair_space
);

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_BIAS,
      RD_WEIGHT,
      RD_PUSH
   } rd_state_e;

   rd_state_e                state;
   logic [`ACCEL_ADDR_W-1:0] addr_r;
   logic [`ACCEL_LEN_W-1:0]  pair_cnt;
   flow_pair_t               pair_r;
   logic                     fire;

   // bias fetch waits for fifo space, which only pops can add to
   assign rd_valid = ((state == RD_BIAS) & pair_space) | (state == RD_WEIGHT);
   assign rd_addr  = addr_r;
   assign fire     = rd_valid & rd_ready;

   // one push per completed pair
   assign pair_valid = (state == RD_PUSH);
   assign pair_data  = pair_r;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= RD_IDLE;
         addr_r   <= '0;
         pair_cnt <= '0;
      end else if (job_clear) begin
         state    <= RD_IDLE;
         addr_r   <= '0;
         pair_cnt <= '0;
      end else if (job_run) begin
         addr_r   <= rd_base;
         pair_cnt <= '0;
         state    <= (len == '0) ? RD_IDLE : RD_BIAS;
      end else begin
         case (state)
            RD_BIAS: begin
               if (fire) begin
                  addr_r <= addr_r + 1'b1;
                  state  <= RD_WEIGHT;
               end
            end
            RD_WEIGHT: begin
               if (fire) begin
                  addr_r <= addr_r + 1'b1;
                  state  <= RD_PUSH;
               end
            end
            RD_PUSH: begin
               pair_cnt <= pair_cnt + 1'b1;
               // last pair ends the fetch loop
               if (pair_cnt == len - 1'b1) begin
                  state <= RD_IDLE;
               end else begin
                  state <= RD_BIAS;
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   // bias held until its weight arrives
   always_ff @(posedge clk) begin
      if (fire) begin
         if (state == RD_BIAS) begin
            pair_r.bias <= rd_rdata;
         end else begin
            pair_r.weight <= rd_rdata;
         end
      end
   end

endmodule

// ==== source/accel_regs.sv ====
`include "accel_defs.svh"

module accel_regs
   import accel_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid,
   input  logic [`ACCEL_ADDR_W-1:0] addr,
   input  logic                     wstrb,
   input  logic [`ACCEL_DATA_W-1:0] wdata,
   output logic                     ready,
   output logic [`ACCEL_DATA_W-1:0] rdata,
   input  logic                     job_done,
   output logic [`ACCEL_ADDR_W-1:0] rd_base,
   output logic [`ACCEL_ADDR_W-1:0] wr_base,
   output logic [`ACCEL_LEN_W-1:0]  len,
   output logic [`ACCEL_DATA_W-1:0] scale,
   output logic                     job_run,
   output logic                     job_clear
);

   reg_sel_e sel;
   logic     addr_hit;
   logic     wr_en;
   logic     run_req_r;
   logic     run_req_d;
   logic     done_r;

   // only the first eight words decode
   assign sel      = reg_sel_e'(addr[2:0]);
   assign addr_hit = (addr[`ACCEL_ADDR_W-1:3] == '0);
   assign wr_en    = valid & wstrb & addr_hit;

   // no back-pressure toward the cpu
   assign ready = 1'b1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_base <= '0;
         wr_base <= '0;
         len     <= '0;
         scale   <= '0;
      end else if (wr_en) begin
         case (sel)
            REG_RD_BASE: rd_base <= wdata[`ACCEL_ADDR_W-1:0];
            REG_WR_BASE: wr_base <= wdata[`ACCEL_ADDR_W-1:0];
            REG_LEN:     len     <= wdata[`ACCEL_LEN_W-1:0];
            REG_SCALE:   scale   <= wdata;
            default: ;
         endcase
      end
   end

   // run request, then edge detect for a single cycle pulse
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_req_r <= 1'b0;
         run_req_d <= 1'b0;
      end else begin
         run_req_r <= wr_en & (sel == REG_CTRL) & wdata[`ACCEL_CTRL_RUN_BIT];
         run_req_d <= run_req_r;
      end
   end

   assign job_run   = run_req_r & ~run_req_d;
   assign job_clear = wr_en & (sel == REG_CTRL) & wdata[`ACCEL_CTRL_CLEAR_BIT];

   // sticky done, clear wins over a completing job
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_r <= 1'b0;
      end else if (job_clear) begin
         done_r <= 1'b0;
      end else if (job_done) begin
         done_r <= 1'b1;
      end else if (job_run) begin
         done_r <= 1'b0;
      end
   end

   // readback mux
   always_comb begin
      rdata = '0;
      if (addr_hit) begin
         case (sel)
            REG_RD_BASE: rdata[`ACCEL_ADDR_W-1:0] = rd_base;
            REG_WR_BASE: rdata[`ACCEL_ADDR_W-1:0] = wr_base;
            REG_LEN:     rdata[`ACCEL_LEN_W-1:0]  = len;
            REG_SCALE:   rdata = scale;
            // hide the old done while the run pulse is in flight
            REG_STATUS:  rdata[`ACCEL_STATUS_DONE_BIT] = done_r & ~job_run;
            default:     rdata = '0;
         endcase
      end
   end

endmodule

// ==== source/stream_fifo.sv ====
`include "accel_defs.svh"

module stream_fifo
   import accel_pkg::*;
#(
   parameter type payload_t = flow_pair_t,
   parameter int  DEPTH     = `ACCEL_FIFO_DEPTH
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     flush,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         // push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

endmodule

// ==== source/accel_pkg.sv ====
`include "accel_defs.svh"

package accel_pkg;

   // one element of the input vector, as fetched by the read unit
   typedef struct packed {
      logic [`ACCEL_DATA_W-1:0] bias;
      logic [`ACCEL_DATA_W-1:0] weight;
   } flow_pair_t;

   // finished result tagged with its write address
   typedef struct packed {
      logic [`ACCEL_ADDR_W-1:0] addr;
      logic [`ACCEL_DATA_W-1:0] data;
   } result_t;

   // cpu register select, low address bits only
   typedef enum logic [2:0] {
      REG_RD_BASE = `ACCEL_REG_RD_BASE,
      REG_WR_BASE = `ACCEL_REG_WR_BASE,
      REG_LEN     = `ACCEL_REG_LEN,
      REG_SCALE   = `ACCEL_REG_SCALE,
      REG_CTRL    = `ACCEL_REG_CTRL,
      REG_STATUS  = `ACCEL_REG_STATUS
   } reg_sel_e;

endpackage

// ==== source/accel_defs.svh ====
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// bus and datapath widths
`define ACCEL_ADDR_W 16
`define ACCEL_DATA_W 32

// job length counter width
`define ACCEL_LEN_W 8

// entries in the pair and result fifos
`define ACCEL_FIFO_DEPTH 4

// cpu register map, word addresses
`define ACCEL_REG_RD_BASE 0
`define ACCEL_REG_WR_BASE 1
`define ACCEL_REG_LEN 2
`define ACCEL_REG_SCALE 3
`define ACCEL_REG_CTRL 4
`define ACCEL_REG_STATUS 5

// ctrl write bits
`define ACCEL_CTRL_RUN_BIT 0
`define ACCEL_CTRL_CLEAR_BIT 1

// status read bits
`define ACCEL_STATUS_DONE_BIT 0

`endif
